// File: rtl/even_pkg.sv
`default_nettype none

package even_pkg;

  // operand and register file geometry
  localparam int data_w     = 128;
  localparam int addr_w     = 7;
  localparam int word_lanes = 4;
  localparam int byte_lanes = 16;
  localparam int word_w     = data_w / word_lanes;
  localparam int byte_w     = data_w / byte_lanes;

  // one pipe entry is write flag, destination and result
  localparam int entry_w = 1 + addr_w + data_w;

  typedef enum logic [6:0] {
    op_a     = 7'd0,
    op_sf    = 7'd1,
    op_ai    = 7'd2,
    op_and   = 7'd3,
    op_or    = 7'd4,
    op_xor   = 7'd5,
    op_shl   = 7'd6,
    op_shli  = 7'd7,
    op_rot   = 7'd8,
    op_cntb  = 7'd9,
    op_absdb = 7'd10,
    op_avgb  = 7'd11,
    // no register write for these two
    op_nop   = 7'd86,
    op_lnop  = 7'd87
  } op_t;

  typedef enum logic [1:0] {
    unit_none      = 2'd0,
    unit_fx_simple = 2'd1,
    unit_fx_shift  = 2'd2,
    unit_byte      = 2'd3
  } unit_t;

endpackage

`default_nettype wire

// File: rtl/issue_stage.sv
`default_nettype none
`timescale 1ns/100ps

module issue_stage import even_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                flush,
  input  wire logic                issue_valid,
  input  wire op_t                 op,
  input  wire logic [addr_w-1:0]   rt_addr,
  input  wire logic [data_w-1:0]   ra_data,
  input  wire logic [data_w-1:0]   rb_data,
  input  wire logic [6:0]          imm7,
  input  wire logic [9:0]          imm10,
  output unit_t                    ex_unit,
  output op_t                      ex_op,
  output logic                     ex_wr,
  output logic [addr_w-1:0]        ex_addr,
  output logic [data_w-1:0]        ex_a,
  output logic [data_w-1:0]        ex_b,
  output logic [word_w-1:0]        ex_imm
);

  unit_t             dec_unit;
  logic [word_w-1:0] dec_imm;

  // unit select, unknown codes fall to none
  always_comb begin
    case (op)
      op_a, op_sf, op_ai, op_and, op_or, op_xor: dec_unit = unit_fx_simple;
      op_shl, op_shli, op_rot:                   dec_unit = unit_fx_shift;
      op_cntb, op_absdb, op_avgb:                dec_unit = unit_byte;
      default:                                   dec_unit = unit_none;
    endcase
  end

  // shift immediate is unsigned, everything else uses the signed imm10
  assign dec_imm = (op == op_shli) ? {{(word_w - 7){1'b0}}, imm7}
                                   : {{(word_w - 10){imm10[9]}}, imm10};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex_unit <= unit_none;
      ex_op   <= op_nop;
      ex_wr   <= 1'b0;
      ex_addr <= '0;
    end else if (flush || !issue_valid) begin
      // squashed or idle slot becomes a bubble
      ex_unit <= unit_none;
      ex_op   <= op_nop;
      ex_wr   <= 1'b0;
      ex_addr <= '0;
    end else begin
      ex_unit <= dec_unit;
      ex_op   <= op;
      ex_wr   <= (dec_unit != unit_none);
      ex_addr <= rt_addr;
    end
  end

  // operands, only meaningful while ex_unit is not none
  always_ff @(posedge clk) begin
    ex_a   <= ra_data;
    ex_b   <= rb_data;
    ex_imm <= dec_imm;
  end

  a_known_op: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> (dec_unit != unit_none) || (op inside {op_nop, op_lnop}))
    else $error("issue of unknown op code %0d", op);

endmodule

`default_nettype wire

// File: rtl/fx_simple_unit.sv
`default_nettype none
`timescale 1ns/100ps

module fx_simple_unit import even_pkg::*; (
  input  wire op_t                 ex_op,
  input  wire logic [data_w-1:0]   ex_a,
  input  wire logic [data_w-1:0]   ex_b,
  input  wire logic [word_w-1:0]   ex_imm,
  output logic [data_w-1:0]        result
);

  logic [data_w-1:0] sum_ab;
  logic [data_w-1:0] diff_ba;
  logic [data_w-1:0] sum_ai;

  // carries stay inside each word lane
  for (genvar i = 0; i < word_lanes; i++) begin : g_lane
    logic [word_w-1:0] a;
    logic [word_w-1:0] b;

    assign a = ex_a[i*word_w +: word_w];
    assign b = ex_b[i*word_w +: word_w];

    assign sum_ab[i*word_w +: word_w]  = a + b;
    assign diff_ba[i*word_w +: word_w] = b - a;
    assign sum_ai[i*word_w +: word_w]  = a + ex_imm;
  end

  always_comb begin
    case (ex_op)
      op_a:    result = sum_ab;
      op_sf:   result = diff_ba;
      op_ai:   result = sum_ai;
      // logic ops need no lane split
      op_and:  result = ex_a & ex_b;
      op_or:   result = ex_a | ex_b;
      op_xor:  result = ex_a ^ ex_b;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/fx_shift_unit.sv
`default_nettype none
`timescale 1ns/100ps

module fx_shift_unit import even_pkg::*; (
  input  wire op_t                 ex_op,
  input  wire logic [data_w-1:0]   ex_a,
  input  wire logic [data_w-1:0]   ex_b,
  input  wire logic [word_w-1:0]   ex_imm,
  output logic [data_w-1:0]        result
);

  for (genvar i = 0; i < word_lanes; i++) begin : g_lane
    logic [word_w-1:0]   a;
    logic [5:0]          sh_amt;
    logic [2*word_w-1:0] rot_full;
    logic [word_w-1:0]   lane_res;

    assign a = ex_a[i*word_w +: word_w];

    // register form takes the amount from the same lane of rb
    assign sh_amt = (ex_op == op_shli) ? ex_imm[5:0] : ex_b[i*word_w +: 6];

    // upper half of the doubled word is the rotated lane
    assign rot_full = {a, a} << ex_b[i*word_w +: 5];

    always_comb begin
      case (ex_op)
        op_shl, op_shli: begin
          // amounts of 32 and up clear the lane
          if (sh_amt[5]) begin
            lane_res = '0;
          end else begin
            lane_res = a << sh_amt[4:0];
          end
        end
        op_rot:  lane_res = rot_full[2*word_w-1 -: word_w];
        default: lane_res = '0;
      endcase
    end

    assign result[i*word_w +: word_w] = lane_res;
  end

endmodule

`default_nettype wire

// File: rtl/byte_unit.sv
`default_nettype none
`timescale 1ns/100ps

module byte_unit import even_pkg::*; (
  input  wire op_t                 ex_op,
  input  wire logic [data_w-1:0]   ex_a,
  input  wire logic [data_w-1:0]   ex_b,
  output logic [data_w-1:0]        result
);

  for (genvar i = 0; i < byte_lanes; i++) begin : g_lane
    logic [byte_w-1:0] a;
    logic [byte_w-1:0] b;
    logic [byte_w:0]   avg_sum;
    logic [byte_w-1:0] lane_res;

    assign a = ex_a[i*byte_w +: byte_w];
    assign b = ex_b[i*byte_w +: byte_w];

    // ninth bit keeps the carry of a + b + 1
    assign avg_sum = {1'b0, a} + {1'b0, b} + 1'b1;

    always_comb begin
      case (ex_op)
        op_cntb:  lane_res = byte_w'($countones(a));
        op_absdb: lane_res = (a > b) ? a - b : b - a;
        op_avgb:  lane_res = avg_sum[byte_w:1];
        default:  lane_res = '0;
      endcase
    end

    assign result[i*byte_w +: byte_w] = lane_res;
  end

endmodule

`default_nettype wire

// File: rtl/result_pipe.sv
`default_nettype none
`timescale 1ns/100ps

module result_pipe import even_pkg::*; #(
  parameter int pipe_depth = 7
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            flush,
  input  wire unit_t                           ex_unit,
  input  wire logic                            ex_wr,
  input  wire logic [addr_w-1:0]               ex_addr,
  input  wire logic [data_w-1:0]               fx_simple_result,
  input  wire logic [data_w-1:0]               fx_shift_result,
  input  wire logic [data_w-1:0]               byte_result,
  output logic [pipe_depth:2]                  fwd_wr,
  output logic [pipe_depth:2][addr_w-1:0]      fwd_addr,
  output logic [pipe_depth:2][data_w-1:0]      fwd_data,
  output logic                                 wb_en,
  output logic [addr_w-1:0]                    wb_addr,
  output logic [data_w-1:0]                    wb_data
);

  logic [data_w-1:0]                sel_result;
  logic [entry_w-1:0]               entry_in;
  // indexed by stage number, stage 2 is the first register
  logic [pipe_depth:2][entry_w-1:0] stage_q;

  always_comb begin
    case (ex_unit)
      unit_fx_simple: sel_result = fx_simple_result;
      unit_fx_shift:  sel_result = fx_shift_result;
      unit_byte:      sel_result = byte_result;
      default:        sel_result = '0;
    endcase
  end

  // flush only kills the instruction now in execute
  assign entry_in = flush ? '0 : {ex_wr, ex_addr, sel_result};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage_q <= '0;
      wb_en   <= 1'b0;
      wb_addr <= '0;
      wb_data <= '0;
    end else begin
      stage_q[2] <= entry_in;
      for (int s = 3; s <= pipe_depth; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
      wb_en   <= stage_q[pipe_depth][entry_w-1];
      wb_addr <= stage_q[pipe_depth][data_w +: addr_w];
      wb_data <= stage_q[pipe_depth][data_w-1:0];
    end
  end

  // unpack every stage for the forwarding network
  for (genvar s = 2; s <= pipe_depth; s++) begin : g_tap
    assign fwd_wr[s]   = stage_q[s][entry_w-1];
    assign fwd_addr[s] = stage_q[s][data_w +: addr_w];
    assign fwd_data[s] = stage_q[s][data_w-1:0];
  end

  a_wb_en_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(wb_en))
    else $error("wb_en is unknown");

endmodule

`default_nettype wire

// File: rtl/even_pipe.sv
`default_nettype none
`timescale 1ns/100ps

module even_pipe import even_pkg::*; #(
  parameter int pipe_depth = 7
) (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            flush,
  input  wire logic                            issue_valid,
  input  wire op_t                             op,
  input  wire logic [addr_w-1:0]               rt_addr,
  input  wire logic [data_w-1:0]               ra_data,
  input  wire logic [data_w-1:0]               rb_data,
  input  wire logic [6:0]                      imm7,
  input  wire logic [9:0]                      imm10,
  output logic [pipe_depth:2]                  fwd_wr,
  output logic [pipe_depth:2][addr_w-1:0]      fwd_addr,
  output logic [pipe_depth:2][data_w-1:0]      fwd_data,
  output logic                                 wb_en,
  output logic [addr_w-1:0]                    wb_addr,
  output logic [data_w-1:0]                    wb_data
);

  unit_t             ex_unit;
  op_t               ex_op;
  logic              ex_wr;
  logic [addr_w-1:0] ex_addr;
  logic [data_w-1:0] ex_a;
  logic [data_w-1:0] ex_b;
  logic [word_w-1:0] ex_imm;
  logic [data_w-1:0] fx_simple_result;
  logic [data_w-1:0] fx_shift_result;
  logic [data_w-1:0] byte_result;

  issue_stage issue_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .issue_valid (issue_valid),
    .op          (op),
    .rt_addr     (rt_addr),
    .ra_data     (ra_data),
    .rb_data     (rb_data),
    .imm7        (imm7),
    .imm10       (imm10),
    .ex_unit     (ex_unit),
    .ex_op       (ex_op),
    .ex_wr       (ex_wr),
    .ex_addr     (ex_addr),
    .ex_a        (ex_a),
    .ex_b        (ex_b),
    .ex_imm      (ex_imm)
  );

  // all three units see the same execute operands
  fx_simple_unit fx_simple_unit_inst (
    .ex_op  (ex_op),
    .ex_a   (ex_a),
    .ex_b   (ex_b),
    .ex_imm (ex_imm),
    .result (fx_simple_result)
  );

  fx_shift_unit fx_shift_unit_inst (
    .ex_op  (ex_op),
    .ex_a   (ex_a),
    .ex_b   (ex_b),
    .ex_imm (ex_imm),
    .result (fx_shift_result)
  );

  byte_unit byte_unit_inst (
    .ex_op  (ex_op),
    .ex_a   (ex_a),
    .ex_b   (ex_b),
    .result (byte_result)
  );

  result_pipe #(
    .pipe_depth (pipe_depth)
  ) result_pipe_inst (
    .clk              (clk),
    .rst              (rst),
    .flush            (flush),
    .ex_unit          (ex_unit),
    .ex_wr            (ex_wr),
    .ex_addr          (ex_addr),
    .fx_simple_result (fx_simple_result),
    .fx_shift_result  (fx_shift_result),
    .byte_result      (byte_result),
    .fwd_wr           (fwd_wr),
    .fwd_addr         (fwd_addr),
    .fwd_data         (fwd_data),
    .wb_en            (wb_en),
    .wb_addr          (wb_addr),
    .wb_data          (wb_data)
  );

endmodule

`default_nettype wire

// File: test/even_pipe_tb.sv
`default_nettype none
`timescale 1ns/100ps

module even_pipe_tb import even_pkg::*; ();

  localparam int depth  = 7;
  localparam int cycles = 3000;

  logic                       clk;
  logic                       rst;
  logic                       flush;
  logic                       issue_valid;
  op_t                        op;
  logic [addr_w-1:0]          rt_addr;
  logic [data_w-1:0]          ra_data;
  logic [data_w-1:0]          rb_data;
  logic [6:0]                 imm7;
  logic [9:0]                 imm10;
  logic [depth:2]             fwd_wr;
  logic [depth:2][addr_w-1:0] fwd_addr;
  logic [depth:2][data_w-1:0] fwd_data;
  logic                       wb_en;
  logic [addr_w-1:0]          wb_addr;
  logic [data_w-1:0]          wb_data;

  logic [31:0]        lcg_state;
  // expected entries in pipe order from issue through write-back
  logic [entry_w-1:0] exp_issue;
  logic [entry_w-1:0] exp_stage [2:depth];
  logic [entry_w-1:0] exp_wb;
  int                 value_errors;
  int                 other_errors;
  op_t                write_ops [0:11] = '{op_a, op_sf, op_ai, op_and, op_or, op_xor,
                                           op_shl, op_shli, op_rot, op_cntb, op_absdb, op_avgb};

  even_pipe #(
    .pipe_depth (depth)
  ) even_pipe_inst (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .issue_valid (issue_valid),
    .op          (op),
    .rt_addr     (rt_addr),
    .ra_data     (ra_data),
    .rb_data     (rb_data),
    .imm7        (imm7),
    .imm10       (imm10),
    .fwd_wr      (fwd_wr),
    .fwd_addr    (fwd_addr),
    .fwd_data    (fwd_data),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // upper halves of two LCG steps
  function automatic logic [31:0] lcg_next();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {hi, lcg_state[31:16]};
  endfunction

  function automatic logic [data_w-1:0] rand_operand();
    logic [data_w-1:0] v;
    logic [31:0]       r;
    for (int i = 0; i < word_lanes; i++) begin
      r = lcg_next();
      // all-ones lanes push carries to the lane edge
      if (r[19:16] == 4'h0) begin
        r = 32'hffff_ffff;
      end
      v[i*32 +: 32] = r;
    end
    return v;
  endfunction

  function automatic logic [data_w-1:0] expected_result(op_t code, logic [data_w-1:0] a,
      logic [data_w-1:0] b, logic [6:0] i7, logic [9:0] i10);
    logic [data_w-1:0] r;
    logic [31:0]       la;
    logic [31:0]       lb;
    logic [8:0]        xa;
    logic [8:0]        xb;
    int                amt;
    int                ones;
    r = '0;
    for (int w = 0; w < word_lanes; w++) begin
      la = a[w*32 +: 32];
      lb = b[w*32 +: 32];
      case (code)
        op_a:  r[w*32 +: 32] = la + lb;
        op_sf: r[w*32 +: 32] = lb - la;
        op_ai: r[w*32 +: 32] = la + {{22{i10[9]}}, i10};
        op_shl, op_shli: begin
          amt = (code == op_shli) ? int'(i7[5:0]) : int'(lb[5:0]);
          r[w*32 +: 32] = (amt >= 32) ? 32'h0 : la << amt;
        end
        op_rot: begin
          amt = int'(lb[4:0]);
          r[w*32 +: 32] = (la << amt) | (la >> (32 - amt));
        end
        default: ;
      endcase
    end
    if (code == op_and) begin
      r = a & b;
    end
    if (code == op_or) begin
      r = a | b;
    end
    if (code == op_xor) begin
      r = a ^ b;
    end
    for (int i = 0; i < byte_lanes; i++) begin
      xa = {1'b0, a[i*8 +: 8]};
      xb = {1'b0, b[i*8 +: 8]};
      ones = 0;
      for (int k = 0; k < 8; k++) begin
        ones += xa[k];
      end
      case (code)
        op_cntb:  r[i*8 +: 8] = 8'(ones);
        op_absdb: r[i*8 +: 8] = (xa >= xb) ? 8'(xa - xb) : 8'(xb - xa);
        op_avgb:  r[i*8 +: 8] = 8'((xa + xb + 9'd1) >> 1);
        default: ;
      endcase
    end
    return r;
  endfunction

  function automatic logic writes_register(op_t code);
    return code inside {op_a, op_sf, op_ai, op_and, op_or, op_xor,
                        op_shl, op_shli, op_rot, op_cntb, op_absdb, op_avgb};
  endfunction

  // runs at the falling edge while the inputs still hold what the last rising edge took
  task automatic advance_model();
    exp_wb = exp_stage[depth];
    for (int s = depth; s > 2; s--) begin
      exp_stage[s] = exp_stage[s-1];
    end
    exp_stage[2] = flush ? '0 : exp_issue;
    if (flush || !issue_valid || !writes_register(op)) begin
      exp_issue = '0;
    end else begin
      exp_issue = {1'b1, rt_addr, expected_result(op, ra_data, rb_data, imm7, imm10)};
    end
  endtask

  task automatic report_value(string name, logic [data_w-1:0] got, logic [data_w-1:0] exp);
    $display("FAIL %s got %0h exp %0h at %0t", name, got, exp, $time);
    value_errors++;
  endtask

  task automatic check_outputs();
    if (wb_en !== exp_wb[entry_w-1]) begin
      report_value("wb_en", wb_en, exp_wb[entry_w-1]);
    end else if (wb_en) begin
      if (wb_addr !== exp_wb[data_w +: addr_w]) begin
        report_value("wb_addr", wb_addr, exp_wb[data_w +: addr_w]);
      end
      if (wb_data !== exp_wb[data_w-1:0]) begin
        report_value("wb_data", wb_data, exp_wb[data_w-1:0]);
      end
    end
    for (int s = 2; s <= depth; s++) begin
      if (fwd_wr[s] !== exp_stage[s][entry_w-1]) begin
        report_value($sformatf("fwd_wr[%0d]", s), fwd_wr[s], exp_stage[s][entry_w-1]);
      end else if (fwd_wr[s]) begin
        if (fwd_addr[s] !== exp_stage[s][data_w +: addr_w]) begin
          report_value($sformatf("fwd_addr[%0d]", s), fwd_addr[s],
                       exp_stage[s][data_w +: addr_w]);
        end
        if (fwd_data[s] !== exp_stage[s][data_w-1:0]) begin
          report_value($sformatf("fwd_data[%0d]", s), fwd_data[s],
                       exp_stage[s][data_w-1:0]);
        end
      end
    end
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] r_imm;
    r = lcg_next();
    r_imm = lcg_next();
    flush = (r[2:0] == 3'd0);
    issue_valid = (r[7:4] < 4'd14);
    // codes 12..15 pick one of the two no-write ops
    if (r[11:8] < 4'd12) begin
      op = write_ops[r[11:8]];
    end else begin
      op = r[8] ? op_lnop : op_nop;
    end
    rt_addr = r[22:16];
    ra_data = rand_operand();
    rb_data = rand_operand();
    imm7 = r_imm[6:0];
    imm10 = r_imm[17:8];
  endtask

  function automatic logic pipe_busy();
    logic busy;
    busy = exp_issue[entry_w-1] || exp_wb[entry_w-1] || wb_en || (fwd_wr != '0);
    for (int s = 2; s <= depth; s++) begin
      busy = busy || exp_stage[s][entry_w-1];
    end
    return busy;
  endfunction

  initial begin
    int drain_wait;
    lcg_state = 32'd63132;
    value_errors = 0;
    other_errors = 0;
    rst = 1'b1;
    flush = 1'b0;
    issue_valid = 1'b0;
    op = op_nop;
    rt_addr = '0;
    ra_data = '0;
    rb_data = '0;
    imm7 = '0;
    imm10 = '0;
    exp_issue = '0;
    exp_wb = '0;
    for (int s = 2; s <= depth; s++) begin
      exp_stage[s] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (wb_en !== 1'b0 || fwd_wr !== '0) begin
      $display("write-back or forwarding flags not cleared by reset");
      other_errors++;
    end
    rst = 1'b0;
    drive_random();
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      advance_model();
      check_outputs();
      drive_random();
    end
    // idle slots until everything has left the pipe
    flush = 1'b0;
    issue_valid = 1'b0;
    drain_wait = 0;
    while (pipe_busy() && drain_wait < 4 * depth) begin
      @(negedge clk);
      advance_model();
      check_outputs();
      drain_wait++;
    end
    if (pipe_busy()) begin
      $display("pipe still holds writes after %0d idle cycles", drain_wait);
      other_errors++;
    end
    $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
rtl/even_pkg.sv
rtl/issue_stage.sv
rtl/fx_simple_unit.sv
rtl/fx_shift_unit.sv
rtl/byte_unit.sv
rtl/result_pipe.sv
rtl/even_pipe.sv
test/even_pipe_tb.sv

// File: Bender.yml
package:
  name: even_pipe

sources:
  - files:
      - rtl/even_pkg.sv
      - rtl/issue_stage.sv
      - rtl/fx_simple_unit.sv
      - rtl/fx_shift_unit.sv
      - rtl/byte_unit.sv
      - rtl/result_pipe.sv
      - rtl/even_pipe.sv
  - target: test
    files:
      - test/even_pipe_tb.sv
